/* hw/cpu_params_pkg.sv */
`default_nettype none

package cpu_params_pkg;

	// ======================================================================
	// Datapath widths
	// ======================================================================

	localparam int data_width      = 32;	// Machine word.
	localparam int reg_index_width = 5;	// Register file index.
	localparam int wb_ctrl_width   = 2;	// Write-back control bits.

	typedef logic [data_width-1:0]      word_t;
	typedef logic [reg_index_width-1:0] reg_index_t;
	typedef logic [wb_ctrl_width-1:0]   wb_ctrl_t;

	// ======================================================================
	// Reset values of the pipeline registers
	// ======================================================================

	localparam word_t      word_reset      = '0;
	localparam reg_index_t reg_index_reset = '0;
	localparam wb_ctrl_t   wb_ctrl_reset   = '0;

	// Halt flag is a single bit.
	localparam logic halt_reset = 1'b0;

endpackage

`default_nettype wire

/* hw/mem_ops_pkg.sv */
`default_nettype none

package mem_ops_pkg;

	// ======================================================================
	// Memory stage opcodes
	// ======================================================================

	typedef enum logic [3:0]
	{
		MEM_NONE = 4'd0,	// No memory access, no branch.
		MEM_LW   = 4'd1,	// Load word.
		MEM_LH   = 4'd2,	// Load halfword, signed.
		MEM_LHU  = 4'd3,	// Load halfword, unsigned.
		MEM_LB   = 4'd4,	// Load byte, signed.
		MEM_LBU  = 4'd5,	// Load byte, unsigned.
		MEM_SW   = 4'd6,	// Store word.
		MEM_SH   = 4'd7,	// Store halfword.
		MEM_SB   = 4'd8,	// Store byte.
		MEM_BEQ  = 4'd9,	// Branch if equal.
		MEM_BNE  = 4'd10	// Branch if not equal.
	} mem_op_e;

	// ======================================================================
	// Access size
	// ======================================================================

	// Stores of halfword or byte size still write the whole word.
	typedef enum logic [1:0]
	{
		SIZE_WORD = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_BYTE = 2'd2
	} access_size_e;

endpackage

`default_nettype wire

/* hw/mem_ctrl_if.sv */
`default_nettype none

interface mem_ctrl_if import mem_ops_pkg::*; ();

	logic         mem_read;	// Instruction is a load.
	logic         mem_write;	// Instruction is a store.
	access_size_e size;	// Load or store width.
	logic         is_unsigned;	// Zero-extend loads.
	logic         branch;	// BEQ or BNE.
	logic         branch_ne;	// Set for BNE only.

	modport decoder
	(
		output mem_read, mem_write, size, is_unsigned, branch, branch_ne
	);

	modport memory
	(
		input mem_write, size
	);

	modport result
	(
		input mem_read, size, is_unsigned, branch, branch_ne
	);

endinterface

`default_nettype wire

/* hw/mem_op_decoder.sv */
`default_nettype none

module mem_op_decoder
	import mem_ops_pkg::*;
(
	input  mem_op_e           mem_op,
	mem_ctrl_if.decoder       ctrl
);

	always_comb
	begin
		// Everything inactive unless the opcode says otherwise.
		ctrl.mem_read    = 1'b0;
		ctrl.mem_write   = 1'b0;
		ctrl.size        = SIZE_WORD;
		ctrl.is_unsigned = 1'b0;
		ctrl.branch      = 1'b0;
		ctrl.branch_ne   = 1'b0;

		case (mem_op)
			MEM_LW:
			begin
				ctrl.mem_read = 1'b1;
			end
			MEM_LH, MEM_LHU:
			begin
				ctrl.mem_read    = 1'b1;
				ctrl.size        = SIZE_HALF;
				ctrl.is_unsigned = (mem_op == MEM_LHU);
			end
			MEM_LB, MEM_LBU:
			begin
				ctrl.mem_read    = 1'b1;
				ctrl.size        = SIZE_BYTE;
				ctrl.is_unsigned = (mem_op == MEM_LBU);
			end
			MEM_SW:
			begin
				ctrl.mem_write = 1'b1;
			end
			MEM_SH:
			begin
				ctrl.mem_write = 1'b1;
				ctrl.size      = SIZE_HALF;
			end
			MEM_SB:
			begin
				ctrl.mem_write = 1'b1;
				ctrl.size      = SIZE_BYTE;
			end
			MEM_BEQ, MEM_BNE:
			begin
				ctrl.branch    = 1'b1;
				ctrl.branch_ne = (mem_op == MEM_BNE);	// Selects the inverted zero test.
			end
			default:
			begin
				// MEM_NONE and unused codes keep the defaults.
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/data_memory.sv */
`default_nettype none

module data_memory
	import cpu_params_pkg::*;
	import mem_ops_pkg::*;
#(
	parameter int addr_bits = 8
)
(
	input  logic         clk,
	input  word_t        addr,
	input  word_t        write_data,
	mem_ctrl_if.memory   ctrl,
	output word_t        read_word
);

	localparam int depth = 2 ** addr_bits;	// Number of words.

	// ======================================================================
	// Store formatting
	// ======================================================================

	word_t store_word;

	always_comb
	begin
		case (ctrl.size)
			SIZE_HALF:
			begin
				store_word = {{(data_width-16){write_data[15]}}, write_data[15:0]};
			end
			SIZE_BYTE:
			begin
				store_word = {{(data_width-8){write_data[7]}}, write_data[7:0]};
			end
			default:
			begin
				store_word = write_data;
			end
		endcase
	end

	// ======================================================================
	// Word array
	// ======================================================================

	logic [addr_bits-1:0] index;	// Word index, upper address bits ignored.
	word_t                mem [depth];

	assign index = addr[addr_bits-1:0];

	// Write at the edge that closes the store cycle.
	always_ff @(posedge clk)
	begin
		if (ctrl.mem_write)
		begin
			mem[index] <= store_word;
		end
	end

	// Asynchronous read so a load right after a store sees the new word.
	assign read_word = mem[index];

endmodule

`default_nettype wire

/* hw/mem_wb_register.sv */
`default_nettype none

module mem_wb_register
	import cpu_params_pkg::*;
	import mem_ops_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	mem_ctrl_if.result   ctrl,
	input  word_t        read_word,
	input  logic         zero_flag,
	input  word_t        alu_result,
	input  reg_index_t   write_reg,
	input  wb_ctrl_t     wb_ctrl,
	input  logic         halt,
	output logic         pc_src,
	output word_t        read_data,
	output word_t        alu_result_wb,
	output reg_index_t   write_reg_wb,
	output wb_ctrl_t     wb_ctrl_wb,
	output logic         halt_wb
);

	// ======================================================================
	// Branch resolution
	// ======================================================================

	// BEQ takes on zero, BNE on nonzero.
	assign pc_src = ctrl.branch & (ctrl.branch_ne ? ~zero_flag : zero_flag);

	// ======================================================================
	// Load extension
	// ======================================================================

	word_t load_word;
	logic  fill_bit;	// Bit copied into the upper part of a sized load.

	always_comb
	begin
		fill_bit  = 1'b0;
		load_word = read_word;	// Words and non-loads pass unchanged.
		if (ctrl.mem_read)
		begin
			case (ctrl.size)
				SIZE_HALF:
				begin
					fill_bit  = ctrl.is_unsigned ? 1'b0 : read_word[15];
					load_word = {{(data_width-16){fill_bit}}, read_word[15:0]};
				end
				SIZE_BYTE:
				begin
					fill_bit  = ctrl.is_unsigned ? 1'b0 : read_word[7];
					load_word = {{(data_width-8){fill_bit}}, read_word[7:0]};
				end
				default:
				begin
					load_word = read_word;
				end
			endcase
		end
	end

	// ======================================================================
	// Write-back register
	// ======================================================================

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			read_data     <= word_reset;
			alu_result_wb <= word_reset;
			write_reg_wb  <= reg_index_reset;
			wb_ctrl_wb    <= wb_ctrl_reset;
			halt_wb       <= halt_reset;
		end
		else
		begin
			read_data     <= load_word;
			alu_result_wb <= alu_result;
			write_reg_wb  <= write_reg;	// Destination index for the register file.
			wb_ctrl_wb    <= wb_ctrl;
			halt_wb       <= halt;
		end
	end

endmodule

`default_nettype wire

/* hw/mem_stage_top.sv */
`default_nettype none

module mem_stage_top
	import cpu_params_pkg::*;
	import mem_ops_pkg::*;
#(
	parameter int addr_bits = 8
)
(
	input  logic       clk,
	input  logic       reset,
	input  mem_op_e    mem_op,
	input  word_t      alu_result,	// Also the memory address.
	input  word_t      write_data,
	input  reg_index_t write_reg,
	input  wb_ctrl_t   wb_ctrl,
	input  logic       zero_flag,
	input  logic       halt,
	output logic       pc_src,
	output word_t      mem_word,	// Word at the current address.
	output word_t      read_data,
	output word_t      alu_result_wb,
	output reg_index_t write_reg_wb,
	output wb_ctrl_t   wb_ctrl_wb,
	output logic       halt_wb
);

	// ======================================================================
	// Decoded controls
	// ======================================================================

	mem_ctrl_if ctrl_bus ();

	mem_op_decoder decoder_i
	(
		.mem_op (mem_op),
		.ctrl   (ctrl_bus.decoder)
	);

	// ======================================================================
	// Memory and write-back register
	// ======================================================================

	word_t read_word;

	data_memory #(
		.addr_bits (addr_bits)
	) data_memory_i
	(
		.clk        (clk),
		.addr       (alu_result),
		.write_data (write_data),
		.ctrl       (ctrl_bus.memory),
		.read_word  (read_word)
	);

	assign mem_word = read_word;	// Unregistered view of the memory.

	mem_wb_register mem_wb_register_i
	(
		.clk           (clk),
		.reset         (reset),
		.ctrl          (ctrl_bus.result),
		.read_word     (read_word),
		.zero_flag     (zero_flag),
		.alu_result    (alu_result),
		.write_reg     (write_reg),
		.wb_ctrl       (wb_ctrl),
		.halt          (halt),
		.pc_src        (pc_src),
		.read_data     (read_data),
		.alu_result_wb (alu_result_wb),
		.write_reg_wb  (write_reg_wb),
		.wb_ctrl_wb    (wb_ctrl_wb),
		.halt_wb       (halt_wb)
	);

endmodule

`default_nettype wire

/* verification/mem_stage_checker.sv */
`default_nettype none

module mem_stage_checker
	import cpu_params_pkg::*;
	import mem_ops_pkg::*;
(
	input logic       clk,
	input logic       reset,
	input mem_op_e    mem_op,
	input logic       halt,
	input logic       pc_src,
	input word_t      read_data,
	input word_t      alu_result_wb,
	input reg_index_t write_reg_wb,
	input wb_ctrl_t   wb_ctrl_wb,
	input logic       halt_wb
);

	int failure_count = 0;	// Read by the testbench at the end.

	// ======================================================================
	// Port properties
	// ======================================================================

	branch_only: assert property (@(posedge clk) disable iff (reset)
		pc_src |-> (mem_op == MEM_BEQ || mem_op == MEM_BNE))
	else
	begin
		$error("pc_src high on a non-branch opcode");
		failure_count++;
	end

	// Registered outputs stay cleared on the edge after a reset cycle.
	reset_clears: assert property (@(posedge clk)
		$past(reset) |-> (read_data == '0 && alu_result_wb == '0 && write_reg_wb == '0
			&& wb_ctrl_wb == '0 && !halt_wb))
	else
	begin
		$error("Registered outputs not zero after reset");
		failure_count++;
	end

	halt_delay: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> (halt_wb == $past(halt)))
	else
	begin
		$error("halt_wb does not follow halt by one cycle");
		failure_count++;
	end

endmodule

bind mem_stage_top mem_stage_checker mem_stage_checker_i
(
	.clk           (clk),
	.reset         (reset),
	.mem_op        (mem_op),
	.halt          (halt),
	.pc_src        (pc_src),
	.read_data     (read_data),
	.alu_result_wb (alu_result_wb),
	.write_reg_wb  (write_reg_wb),
	.wb_ctrl_wb    (wb_ctrl_wb),
	.halt_wb       (halt_wb)
);

`default_nettype wire

/* verification/mem_stage_tb.sv */
`default_nettype none

module mem_stage_tb
	import cpu_params_pkg::*;
	import mem_ops_pkg::*;
();

	logic       clk;
	logic       reset;
	mem_op_e    mem_op;
	word_t      alu_result;
	word_t      write_data;
	reg_index_t write_reg;
	wb_ctrl_t   wb_ctrl;
	logic       zero_flag;
	logic       halt;
	logic       pc_src;
	word_t      mem_word;
	word_t      read_data;
	word_t      alu_result_wb;
	reg_index_t write_reg_wb;
	wb_ctrl_t   wb_ctrl_wb;
	logic       halt_wb;

	word_t      ref_mem [256];	// Reference copy of the data memory.
	integer     seed;
	string      test_name;
	int         tests_done;
	int         checks_run;
	int         errors;
	int         test_errors;

	// Item presented in the previous cycle, expected at the outputs now.
	logic       prev_valid;
	word_t      prev_read;
	word_t      prev_alu;
	reg_index_t prev_reg;
	wb_ctrl_t   prev_wb;
	logic       prev_halt;

	mem_stage_top mem_stage_top_i
	(
		.clk           (clk),
		.reset         (reset),
		.mem_op        (mem_op),
		.alu_result    (alu_result),
		.write_data    (write_data),
		.write_reg     (write_reg),
		.wb_ctrl       (wb_ctrl),
		.zero_flag     (zero_flag),
		.halt          (halt),
		.pc_src        (pc_src),
		.mem_word      (mem_word),
		.read_data     (read_data),
		.alu_result_wb (alu_result_wb),
		.write_reg_wb  (write_reg_wb),
		.wb_ctrl_wb    (wb_ctrl_wb),
		.halt_wb       (halt_wb)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ======================================================================
	// Reference model of the store and load rules
	// ======================================================================

	function automatic word_t store_format(input mem_op_e op, input word_t data);
		case (op)
			MEM_SH:  return {{16{data[15]}}, data[15:0]};
			MEM_SB:  return {{24{data[7]}}, data[7:0]};
			default: return data;
		endcase
	endfunction

	function automatic word_t load_extend(input mem_op_e op, input word_t w);
		case (op)
			MEM_LH:  return {{16{w[15]}}, w[15:0]};
			MEM_LHU: return {16'h0000, w[15:0]};
			MEM_LB:  return {{24{w[7]}}, w[7:0]};
			MEM_LBU: return {24'h000000, w[7:0]};
			default: return w;	// Words and non-loads give the raw word.
		endcase
	endfunction

	function automatic word_t fill_pattern(input logic [7:0] a);
		return {~a, a ^ 8'h3c, a, 8'ha5};
	endfunction

	// ======================================================================
	// Compare tasks
	// ======================================================================

	task automatic compare_word(input string what, input word_t exp, input word_t act);
		checks_run++;
		if (act !== exp)
		begin
			errors++;
			test_errors++;
			$display("Error in %s, %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic compare_reg(input string what, input reg_index_t exp, input reg_index_t act);
		checks_run++;
		if (act !== exp)
		begin
			errors++;
			test_errors++;
			$display("Error in %s, %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic compare_wb(input string what, input wb_ctrl_t exp, input wb_ctrl_t act);
		checks_run++;
		if (act !== exp)
		begin
			errors++;
			test_errors++;
			$display("Error in %s, %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic compare_bit(input string what, input logic exp, input logic act);
		checks_run++;
		if (act !== exp)
		begin
			errors++;
			test_errors++;
			$display("Error in %s, %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	// ======================================================================
	// Cycle driver
	// ======================================================================

	// One instruction per call; also checks the one before it.
	task automatic run_cycle(input mem_op_e op, input word_t addr, input word_t data,
		input reg_index_t wr, input wb_ctrl_t wb, input logic zero, input logic hlt);
		logic exp_pc;
		@(negedge clk);
		if (prev_valid)
		begin
			compare_word("read_data", prev_read, read_data);
			compare_word("alu_result_wb", prev_alu, alu_result_wb);
			compare_reg("write_reg_wb", prev_reg, write_reg_wb);
			compare_wb("wb_ctrl_wb", prev_wb, wb_ctrl_wb);
			compare_bit("halt_wb", prev_halt, halt_wb);
		end
		mem_op     = op;
		alu_result = addr;
		write_data = data;
		write_reg  = wr;
		wb_ctrl    = wb;
		zero_flag  = zero;
		halt       = hlt;
		#10;	// Let the combinational paths settle.
		exp_pc = (op == MEM_BEQ && zero) || (op == MEM_BNE && !zero);
		compare_bit("pc_src", exp_pc, pc_src);
		compare_word("mem_word", ref_mem[addr[7:0]], mem_word);
		prev_valid = 1'b1;
		prev_read  = load_extend(op, ref_mem[addr[7:0]]);
		prev_alu   = addr;
		prev_reg   = wr;
		prev_wb    = wb;
		prev_halt  = hlt;
		if (op == MEM_SW || op == MEM_SH || op == MEM_SB)
			ref_mem[addr[7:0]] = store_format(op, data);	// Lands at the coming edge.
	endtask

	task automatic report_test();
		$display("Test %s finished with %0d errors", test_name, test_errors);
		tests_done++;
		test_errors = 0;
	endtask

	task automatic finish_test();
		run_cycle(MEM_NONE, '0, '0, '0, '0, 1'b0, 1'b0);	// Drains the last item.
		report_test();
	endtask

	task automatic check_outputs_zero();
		compare_word("read_data", '0, read_data);
		compare_word("alu_result_wb", '0, alu_result_wb);
		compare_reg("write_reg_wb", '0, write_reg_wb);
		compare_wb("wb_ctrl_wb", '0, wb_ctrl_wb);
		compare_bit("halt_wb", 1'b0, halt_wb);
	endtask

	// ======================================================================
	// Tests
	// ======================================================================

	task automatic check_reset();
		int cycles;
		test_name = "reset";
		for (int k = 0; k < 3; k++)
		begin
			@(negedge clk);
			mem_op     = MEM_LW;	// Busy inputs that reset must override.
			alu_result = 32'h0000_0055;
			write_reg  = 5'h1f;
			wb_ctrl    = 2'b11;
			halt       = 1'b1;
			check_outputs_zero();
		end
		reset      = 1'b0;
		mem_op     = MEM_NONE;
		alu_result = 32'h0000_00a5;	// Marker that shows the register running.
		write_reg  = '0;
		wb_ctrl    = '0;
		halt       = 1'b0;
		check_outputs_zero();
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (alu_result_wb !== 32'h0000_00a5 && cycles < 8);
		prev_valid = 1'b0;
		report_test();
		if (alu_result_wb !== 32'h0000_00a5)
		begin
			$display("The DUT did not leave reset within 8 cycles");
			$display("=== FAIL ===");
			$finish;
		end
	endtask

	task automatic preload_memory();
		for (int i = 0; i < 256; i++)
		begin
			@(negedge clk);
			mem_op     = MEM_SW;
			alu_result = i;
			write_data = fill_pattern(i[7:0]);
			ref_mem[i] = fill_pattern(i[7:0]);
		end
		prev_valid = 1'b0;
	endtask

	task automatic test_word_access();
		test_name = "word_access";
		run_cycle(MEM_SW, 32'h10, 32'hdead_beef, 5'd1, 2'b01, 1'b0, 1'b0);
		run_cycle(MEM_LW, 32'h10, '0, 5'd2, 2'b10, 1'b0, 1'b0);
		compare_word("mem_word after sw", 32'hdead_beef, mem_word);
		run_cycle(MEM_NONE, 32'h11, '0, 5'd3, 2'b00, 1'b0, 1'b0);
		compare_word("read_data of lw", 32'hdead_beef, read_data);
		finish_test();
	endtask

	task automatic test_sized_access();
		mem_op_e load_ops [4];
		word_t   load_addrs [4];
		load_ops   = '{MEM_LH, MEM_LHU, MEM_LB, MEM_LBU};
		load_addrs = '{32'h20, 32'h21, 32'h22, 32'h24};
		test_name = "sized_access";
		run_cycle(MEM_SH, 32'h20, 32'h1234_8001, 5'd4, 2'b01, 1'b0, 1'b0);
		run_cycle(MEM_SB, 32'h21, 32'h0000_0a7f, 5'd5, 2'b01, 1'b0, 1'b0);
		run_cycle(MEM_SB, 32'h22, 32'h0000_0080, 5'd6, 2'b01, 1'b0, 1'b0);
		run_cycle(MEM_SW, 32'h24, 32'h0000_80f0, 5'd7, 2'b01, 1'b0, 1'b0);
		run_cycle(MEM_LW, 32'h20, '0, 5'd8, 2'b10, 1'b0, 1'b0);
		compare_word("mem_word after sh", 32'hffff_8001, mem_word);
		run_cycle(MEM_LW, 32'h21, '0, 5'd9, 2'b10, 1'b0, 1'b0);
		compare_word("mem_word after sb", 32'h0000_007f, mem_word);
		run_cycle(MEM_LW, 32'h22, '0, 5'd10, 2'b10, 1'b0, 1'b0);
		compare_word("mem_word after sb", 32'hffff_ff80, mem_word);
		foreach (load_addrs[a])
			foreach (load_ops[k])
				run_cycle(load_ops[k], load_addrs[a], '0, 5'(a * 4 + k), 2'(k), 1'b0, 1'b0);
		run_cycle(MEM_LB, 32'h24, '0, 5'd11, 2'b11, 1'b0, 1'b0);
		run_cycle(MEM_NONE, '0, '0, 5'd12, 2'b00, 1'b0, 1'b0);
		compare_word("read_data of lb", 32'hffff_fff0, read_data);
		finish_test();
	endtask

	task automatic test_branches();
		mem_op_e ops [5];
		ops = '{MEM_BEQ, MEM_BNE, MEM_LW, MEM_SW, MEM_NONE};
		test_name = "branches";
		foreach (ops[k])
		begin
			run_cycle(ops[k], 32'h30, 32'h0000_1111, 5'd13, 2'b01, 1'b0, 1'b0);
			run_cycle(ops[k], 32'h30, 32'h0000_2222, 5'd14, 2'b10, 1'b1, 1'b0);
		end
		finish_test();
	endtask

	task automatic test_back_to_back();
		test_name = "back_to_back";
		for (int i = 0; i < 8; i++)
			run_cycle(i[0] ? MEM_LHU : MEM_LW, 32'h40 + i, '0, 5'(i + 3), 2'(i), 1'b0, i[0]);
		finish_test();
	endtask

	task automatic test_random();
		word_t rand_val;
		word_t data;
		test_name = "random";
		for (int i = 0; i < 200; i++)
		begin
			rand_val = $random(seed);
			data     = $random(seed);
			run_cycle(mem_op_e'(rand_val[3:0] % 4'd11), {24'h0, rand_val[11:4]}, data,
				rand_val[16:12], rand_val[18:17], rand_val[19], rand_val[20]);
		end
		finish_test();
	endtask

	// ======================================================================
	// Sequence
	// ======================================================================

	initial
	begin
		seed        = 32'h52aa1cdb;
		reset       = 1'b1;
		mem_op      = MEM_NONE;
		alu_result  = '0;
		write_data  = '0;
		write_reg   = '0;
		wb_ctrl     = '0;
		zero_flag   = 1'b0;
		halt        = 1'b0;
		prev_valid  = 1'b0;
		tests_done  = 0;
		checks_run  = 0;
		errors      = 0;
		test_errors = 0;
		check_reset();
		preload_memory();
		test_word_access();
		test_sized_access();
		test_branches();
		test_back_to_back();
		test_random();
		errors += mem_stage_top_i.mem_stage_checker_i.failure_count;	// Assertion failures.
		$display("Tests: %0d, checks: %0d, errors: %0d", tests_done, checks_run, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
hw/cpu_params_pkg.sv
hw/mem_ops_pkg.sv
hw/mem_ctrl_if.sv
hw/mem_op_decoder.sv
hw/data_memory.sv
hw/mem_wb_register.sv
hw/mem_stage_top.sv
verification/mem_stage_checker.sv
verification/mem_stage_tb.sv

/* Makefile */
TOP := mem_stage_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

# The run passes only if the pass line shows up in the output.
sim:
	verilator --binary --assert --top-module $(TOP) -f verilog.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q -F "=== PASS ==="

clean:
	rm -rf obj_dir
